//--- cart_pkg.sv
// Shared types and constants for the C64 cartridge bank mapper
package cart_pkg;

	// ****************************************
	// Address and bank types
	// ****************************************
	typedef logic [6:0]  bank_t;       // One of 128 banks of 8 KiB
	typedef logic [5:0]  bank_idx_t;   // One of 64 table entries
	typedef logic [24:0] sdram_addr_t; // SDRAM byte address
	typedef logic [17:0] cpu_addr_t;   // CPU side address

	localparam int TABLE_DEPTH = 64;

	localparam logic [15:0] BANK_SIZE_8K = 16'h2000;
	localparam logic [15:0] ROML_LIMIT   = 16'h8000; // Highest load address of a low bank

	// ****************************************
	// Cartridge ids from the CRT header
	// ****************************************
	localparam logic [15:0] CART_GENERIC    = 16'd0;
	localparam logic [15:0] CART_OCEAN      = 16'd5;
	localparam logic [15:0] CART_C64GS      = 16'd15;
	localparam logic [15:0] CART_MAGIC_DESK = 16'd19;
	localparam logic [15:0] CART_EASYFLASH  = 16'd32;
	localparam logic [15:0] CART_NONE       = 16'd255;

	// ****************************************
	// Line modes
	// ****************************************
	// Encoded as {exrom, game}, both lines active low
	typedef enum logic [1:0] {
		MODE_16K     = 2'b00, // ROML and ROMH visible
		MODE_8K      = 2'b01, // ROML only
		MODE_ULTIMAX = 2'b10, // ROMH replaces the kernal area
		MODE_OFF     = 2'b11  // No cartridge visible
	} line_mode_t;

	// Bank base inside a CRT area of 1 MiB
	localparam int BANK_SHIFT = 13;

	// Byte offset width inside one bank
	localparam int OFFSET_BITS = BANK_SHIFT;

endpackage

//--- bank_state_if.sv
// Banking state carried from the cartridge mapper to the address translator
interface bank_state_if import cart_pkg::*; ();

	bank_t bank_lo;    // Bank mapped to ROML
	bank_t bank_hi;    // Bank mapped to ROMH
	logic  bank_lo_en; // ROML window holds data
	logic  bank_hi_en; // ROMH window holds data
	logic  exrom;      // Cartridge EXROM line
	logic  game;       // Cartridge GAME line

	// Register side
	modport mapper (
		output bank_lo,
		output bank_hi,
		output bank_lo_en,
		output bank_hi_en,
		output exrom,
		output game
	);

	// Combinational translation side
	modport translate (
		input bank_lo,
		input bank_hi,
		input bank_lo_en,
		input bank_hi_en,
		input exrom,
		input game
	);

endinterface

//--- bank_table.sv
// Bank table that keeps the CRT chip entries and the bank count during loading
module bank_table import cart_pkg::*; (
	input  logic        clk32,
	input  logic        cart_loading,
	input  logic        cart_bank_wr,     // One strobe per CHIP packet
	input  logic [15:0] cart_bank_num,
	input  logic [15:0] cart_bank_laddr,
	input  logic [15:0] cart_bank_size,
	input  sdram_addr_t cart_bank_raddr,  // Where the packet landed in SDRAM
	input  bank_idx_t   lookup_idx,
	output bank_t       lo_entry,
	output bank_t       hi_entry,
	output logic [7:0]  bank_cnt
);

	bank_t lo_table [TABLE_DEPTH];
	bank_t hi_table [TABLE_DEPTH];

	logic [TABLE_DEPTH-1:0] lo_map; // Entry has been loaded
	logic [TABLE_DEPTH-1:0] hi_map;

	logic      loading_q;
	logic      load_start;
	bank_idx_t wr_idx;
	bank_t     wr_bank;

	assign load_start = cart_loading & ~loading_q;
	assign wr_idx     = cart_bank_num[5:0];
	assign wr_bank    = cart_bank_raddr[19:13]; // 8 KiB bank inside the CRT area

	always_ff @(posedge clk32) begin
		loading_q <= cart_loading;
	end

	// ****************************************
	// Table write
	// ****************************************
	always_ff @(posedge clk32) begin
		if (load_start) begin
			bank_cnt <= '0;
			lo_map   <= '0;
			hi_map   <= '0;
		end
		if (cart_bank_wr) begin
			bank_cnt <= bank_cnt + 8'd1;
			if (cart_bank_num < TABLE_DEPTH) begin
				if (cart_bank_laddr <= ROML_LIMIT) begin
					lo_table[wr_idx] <= wr_bank;
					lo_map[wr_idx]   <= 1'b1;
					// 16 KiB chip spills into ROMH
					if (cart_bank_size > BANK_SIZE_8K) begin
						hi_table[wr_idx] <= wr_bank + 7'd1;
						hi_map[wr_idx]   <= 1'b1;
					end
				end else begin
					hi_table[wr_idx] <= wr_bank;
					hi_map[wr_idx]   <= 1'b1;
				end
			end
		end
	end

	// Entries that were never loaded read as bank 0
	assign lo_entry = lo_map[lookup_idx] ? lo_table[lookup_idx] : '0;
	assign hi_entry = hi_map[lookup_idx] ? hi_table[lookup_idx] : '0;

	// A packet strobe on the loading start edge would be lost by the clear
	a_no_wr_on_start: assert property (@(posedge clk32) load_start |-> !cart_bank_wr)
		else $error("bank table write collides with start of loading");

endmodule

//--- cart_mapper.sv
// Cartridge mapper with bank switching registers and EXROM/GAME lines per cartridge type
module cart_mapper import cart_pkg::*; (
	input  logic        clk32,
	input  logic        reset_n,
	input  logic [15:0] cart_id,
	input  logic [7:0]  cart_exrom,    // EXROM value from the CRT header
	input  logic [7:0]  cart_game,     // GAME value from the CRT header
	input  logic        cart_boot,     // EasyFlash boot jumper
	input  logic        cart_bank_wr,
	input  logic [15:0] cart_bank_num,
	input  logic        ioe,
	input  logic        mem_write,
	input  cpu_addr_t   addr_in,
	input  logic [7:0]  data_in,
	input  bank_t       lo_entry,
	input  bank_t       hi_entry,
	input  logic [7:0]  bank_cnt,
	output bank_idx_t   lookup_idx,
	bank_state_if.mapper state
);

	logic        ioe_q;
	logic [15:0] id_q;
	logic        init_n;  // Low in the first cycle after a clear
	bank_idx_t   bank_no; // EasyFlash table index

	logic  ioe_stb;
	logic  ioe_wr;
	logic  ioe_rd;
	logic  id_change;
	logic  ef_bank_wr;
	bank_t md_bank;

	always_ff @(posedge clk32) begin
		ioe_q <= ioe;
		id_q  <= cart_id;
	end

	assign ioe_stb    = ioe & ~ioe_q;       // First cycle of an IOE access
	assign ioe_wr     = ioe_stb & mem_write;
	assign ioe_rd     = ioe_stb & ~mem_write;
	assign id_change  = id_q != cart_id;
	assign ef_bank_wr = (cart_id == CART_EASYFLASH) & ioe_wr & ~addr_in[1];

	// Table lookup follows a DE00 write in the same cycle
	assign lookup_idx = ef_bank_wr ? data_in[5:0] : bank_no;

	// Magic Desk bank width grows with the number of loaded banks
	always_comb begin
		if (bank_cnt <= 8'd16) begin
			md_bank = {3'b000, data_in[3:0]};
		end else if (bank_cnt <= 8'd32) begin
			md_bank = {2'b00, data_in[4:0]};
		end else if (bank_cnt <= 8'd64) begin
			md_bank = {1'b0, data_in[5:0]};
		end else begin
			md_bank = data_in[6:0];
		end
	end

	// ****************************************
	// Banking registers
	// ****************************************
	always_ff @(posedge clk32) begin
		init_n <= 1'b1;
		if (reset_n || id_change) begin
			init_n                   <= 1'b0;
			bank_no                  <= '0;
			state.bank_lo            <= '0;
			state.bank_hi            <= '0;
			state.bank_lo_en         <= 1'b0;
			state.bank_hi_en         <= 1'b0;
			{state.exrom, state.game} <= MODE_OFF;
		end else if (cart_id == CART_NONE) begin
			state.bank_lo_en <= 1'b0;
			state.bank_hi_en <= 1'b0;
		end else begin
			state.bank_lo_en <= 1'b1;
			state.bank_hi_en <= 1'b1;
			case (cart_id)
				CART_GENERIC: begin
					{state.exrom, state.game} <= {cart_exrom[0], cart_game[0]};
					state.bank_lo <= lo_entry; // Table entry 0
					state.bank_hi <= hi_entry;
				end

				// Bank in DE00 bits 5..0 mirrored to both windows
				CART_OCEAN: begin
					if (!init_n) begin
						{state.exrom, state.game} <= MODE_16K;
					end
					if (ioe_wr) begin
						state.bank_lo <= {1'b0, data_in[5:0]};
						state.bank_hi <= {1'b0, data_in[5:0]};
					end
					// Large images leave A000 as RAM
					if (cart_bank_wr && cart_bank_num >= 16'd32) begin
						state.game <= 1'b1;
					end
				end

				CART_C64GS: begin
					{state.exrom, state.game} <= MODE_8K;
					if (ioe_rd) begin
						state.bank_lo <= '0;
					end
					if (ioe_wr) begin
						state.bank_lo <= {1'b0, addr_in[5:0]}; // Bank from the address
					end
				end

				CART_MAGIC_DESK: begin
					if (!init_n) begin
						{state.exrom, state.game} <= MODE_8K;
						state.bank_lo <= '0;
					end
					if (ioe_wr) begin
						state.bank_lo <= md_bank;
						state.exrom   <= data_in[7]; // Bit 7 hides the cartridge
					end
				end

				CART_EASYFLASH: begin
					if (!init_n) begin
						state.exrom <= 1'b1;
						state.game  <= ~cart_boot; // Boots in ultimax with the jumper set
					end
					if (ioe_wr && addr_in[1]) begin
						state.game  <= ~data_in[0] & data_in[2];
						state.exrom <= ~data_in[1];
					end
					if (ef_bank_wr) begin
						bank_no <= data_in[5:0];
					end
					state.bank_lo <= lo_entry;
					state.bank_hi <= hi_entry;
				end

				default: begin
					state.bank_lo_en <= 1'b0;
					state.bank_hi_en <= 1'b0;
				end
			endcase
		end
	end

	a_lines_known: assert property (@(posedge clk32) disable iff (reset_n)
		!$isunknown({state.exrom, state.game}))
		else $error("EXROM or GAME unknown after reset");

endmodule

//--- addr_translate.sv
// Address translator from CPU accesses to the SDRAM CRT and RAM areas
module addr_translate import cart_pkg::*; #(
	parameter sdram_addr_t RAM_ADDR = 25'h000_0000, // 256 KiB aligned
	parameter sdram_addr_t CRT_ADDR = 25'h010_0000  // 1 MiB aligned
) (
	input  logic         reset_n,
	input  logic         roml,
	input  logic         romh,
	input  logic         mem_write,
	input  cpu_addr_t    addr_in,
	bank_state_if.translate state,
	output sdram_addr_t  mem_addr,
	output logic         mem_write_out,
	output logic         data_floating
);

	logic ultimax;
	logic rom_sel;

	assign ultimax = line_mode_t'({state.exrom, state.game}) == MODE_ULTIMAX;
	assign rom_sel = roml | romh;

	// ****************************************
	// Address mapping
	// ****************************************
	always_comb begin
		mem_addr      = {RAM_ADDR[24:18], addr_in}; // Plain RAM access
		data_floating = 1'b0;
		if (roml && !mem_write) begin
			mem_addr      = {CRT_ADDR[24:20], state.bank_lo, addr_in[OFFSET_BITS-1:0]};
			data_floating = ~state.bank_lo_en;
		end
		if (romh && !mem_write) begin
			mem_addr      = {CRT_ADDR[24:20], state.bank_hi, addr_in[OFFSET_BITS-1:0]};
			data_floating = ~state.bank_hi_en;
		end
	end

	// No RAM sits under the ROM windows in ultimax mode
	assign mem_write_out = mem_write & ~(rom_sel & ultimax);

	always_comb begin
		if (!reset_n) begin
			a_one_window: assert final (!(roml && romh))
				else $error("ROML and ROMH selected together");
		end
	end

endmodule

//--- cartridge.sv
// Top level of the C64 cartridge bank mapper with table, mapper and translator
module cartridge import cart_pkg::*; #(
	parameter sdram_addr_t RAM_ADDR = 25'h000_0000,
	parameter sdram_addr_t CRT_ADDR = 25'h010_0000
) (
	input  logic        clk32,
	input  logic        reset_n,
	input  logic        cart_loading,
	input  logic [15:0] cart_id,
	input  logic [7:0]  cart_exrom,
	input  logic [7:0]  cart_game,
	input  logic        cart_boot,
	input  logic        cart_bank_wr,
	input  logic [15:0] cart_bank_num,
	input  logic [15:0] cart_bank_laddr,
	input  logic [15:0] cart_bank_size,
	input  sdram_addr_t cart_bank_raddr,
	input  logic        romL,
	input  logic        romH,
	input  logic        IOE,
	input  logic        mem_write,
	input  cpu_addr_t   addr_in,
	input  logic [7:0]  data_in,
	output logic        exrom,
	output logic        game,
	output sdram_addr_t mem_addr,
	output logic        mem_write_out,
	output logic        data_floating
);

	bank_idx_t  lookup_idx;
	bank_t      lo_entry;
	bank_t      hi_entry;
	logic [7:0] bank_cnt;

	bank_state_if bank_state ();

	bank_table u_table (
		.clk32           (clk32),
		.cart_loading    (cart_loading),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_raddr (cart_bank_raddr),
		.lookup_idx      (lookup_idx),
		.lo_entry        (lo_entry),
		.hi_entry        (hi_entry),
		.bank_cnt        (bank_cnt)
	);

	cart_mapper u_mapper (
		.clk32         (clk32),
		.reset_n       (reset_n),
		.cart_id       (cart_id),
		.cart_exrom    (cart_exrom),
		.cart_game     (cart_game),
		.cart_boot     (cart_boot),
		.cart_bank_wr  (cart_bank_wr),
		.cart_bank_num (cart_bank_num),
		.ioe           (IOE),
		.mem_write     (mem_write),
		.addr_in       (addr_in),
		.data_in       (data_in),
		.lo_entry      (lo_entry),
		.hi_entry      (hi_entry),
		.bank_cnt      (bank_cnt),
		.lookup_idx    (lookup_idx),
		.state         (bank_state.mapper)
	);

	addr_translate #(
		.RAM_ADDR (RAM_ADDR),
		.CRT_ADDR (CRT_ADDR)
	) u_translate (
		.reset_n       (reset_n),
		.roml          (romL),
		.romh          (romH),
		.mem_write     (mem_write),
		.addr_in       (addr_in),
		.state         (bank_state.translate),
		.mem_addr      (mem_addr),
		.mem_write_out (mem_write_out),
		.data_floating (data_floating)
	);

	assign exrom = bank_state.exrom;
	assign game  = bank_state.game;

endmodule

//--- tb_cartridge.sv
// Testbench for the cartridge bank mapper, driven by commands from a vector file
module tb_cartridge import cart_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam sdram_addr_t RAM_BASE = 25'h004_0000;
	localparam sdram_addr_t CRT_BASE = 25'h020_0000;
	localparam int MAX_CMDS   = 200; // Bound on the command loop
	localparam int SETTLE_MAX = 20;

	logic        clk32 = 1'b0;
	logic        reset_n;
	logic        cart_loading;
	logic [15:0] cart_id;
	logic [7:0]  cart_exrom;
	logic [7:0]  cart_game;
	logic        cart_boot;
	logic        cart_bank_wr;
	logic [15:0] cart_bank_num;
	logic [15:0] cart_bank_laddr;
	logic [15:0] cart_bank_size;
	sdram_addr_t cart_bank_raddr;
	logic        romL;
	logic        romH;
	logic        IOE;
	logic        mem_write;
	cpu_addr_t   addr_in;
	logic [7:0]  data_in;
	logic        exrom;
	logic        game;
	sdram_addr_t mem_addr;
	logic        mem_write_out;
	logic        data_floating;

	int fd;
	int r;
	int n_cmds;
	int n_checks;
	logic [7:0] cmd;
	logic       done;

	cartridge #(.RAM_ADDR(RAM_BASE), .CRT_ADDR(CRT_BASE)) dut (.*);

	always #4 clk32 = ~clk32; // 8 ns period

	// ****************************************
	// Checks
	// ****************************************
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "Value mismatch on %s", name);
		end
		n_checks++;
	endtask

	task automatic fail_run(input string why);
		$display("*** FAILED ***");
		$fatal(1, "%s", why);
	endtask

	// Outputs are sampled just after the rising edge, away from input changes
	task automatic check_outputs(input logic [31:0] ex, gm, addr, wr, fl);
		@(posedge clk32);
		#1;
		check_val("exrom", 32'(exrom), ex);
		check_val("game", 32'(game), gm);
		check_val("mem_addr", 32'(mem_addr), addr);
		check_val("mem_write_out", 32'(mem_write_out), wr);
		check_val("data_floating", 32'(data_floating), fl);
	endtask

	task automatic wait_lines_off(input int max_cycles);
		int n;
		n = 0;
		while (!(exrom === 1'b1 && game === 1'b1)) begin
			if (n == max_cycles) fail_run("Timeout: EXROM and GAME never went high after reset");
			@(posedge clk32);
			n++;
		end
	endtask

	// ****************************************
	// Stimulus, all on the falling edge
	// ****************************************
	task automatic set_cart(input logic [15:0] id, input logic [7:0] ex, gm, input logic boot);
		@(negedge clk32);
		cart_loading = 1'b0; // Ends any earlier load
		cart_id      = id;
		cart_exrom   = ex;
		cart_game    = gm;
		cart_boot    = boot;
	endtask

	task automatic load_bank(input logic [15:0] num, laddr, size, input sdram_addr_t raddr);
		if (!cart_loading) begin
			@(negedge clk32);
			cart_loading = 1'b1; // Table clears on this edge, so no strobe here
		end
		@(negedge clk32);
		cart_bank_wr    = 1'b1;
		cart_bank_num   = num;
		cart_bank_laddr = laddr;
		cart_bank_size  = size;
		cart_bank_raddr = raddr;
		@(negedge clk32);
		cart_bank_wr = 1'b0;
	endtask

	task automatic drive_ioe(input logic write, input cpu_addr_t addr, input logic [7:0] data);
		@(negedge clk32);
		romL      = 1'b0;
		romH      = 1'b0;
		IOE       = 1'b1;
		mem_write = write;
		addr_in   = addr;
		data_in   = data;
		@(negedge clk32);
		IOE       = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic rom_access(input logic l, h, w, input cpu_addr_t addr);
		@(negedge clk32);
		IOE       = 1'b0;
		romL      = l;
		romH      = h;
		mem_write = w;
		addr_in   = addr;
	endtask

	task automatic run_command(input logic [7:0] c);
		logic [31:0] f0, f1, f2, f3, f4;
		logic [8*128-1:0] skip_line;
		int n;
		case (c)
			"#": n = $fgets(skip_line, fd); // Column notes
			"I": begin
				n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
				if (n != 4) fail_run("Malformed I line in cart_input.txt");
				set_cart(f0[15:0], f1[7:0], f2[7:0], f3[0]);
			end
			"L": begin
				n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
				if (n != 4) fail_run("Malformed L line in cart_input.txt");
				load_bank(f0[15:0], f1[15:0], f2[15:0], f3[24:0]);
			end
			"W": begin
				n = $fscanf(fd, "%h %h", f0, f1);
				if (n != 2) fail_run("Malformed W line in cart_input.txt");
				drive_ioe(1'b1, f0[17:0], f1[7:0]);
			end
			"R": begin
				n = $fscanf(fd, "%h", f0);
				if (n != 1) fail_run("Malformed R line in cart_input.txt");
				drive_ioe(1'b0, f0[17:0], 8'h00);
			end
			"A": begin
				n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
				if (n != 4) fail_run("Malformed A line in cart_input.txt");
				rom_access(f0[0], f1[0], f2[0], f3[17:0]);
			end
			"E": begin
				n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
				if (n != 5) fail_run("Malformed E line in cart_input.txt");
				check_outputs(f0, f1, f2, f3, f4);
			end
			default: fail_run("Unknown command letter in cart_input.txt");
		endcase
	endtask

	initial begin
		reset_n         = 1'b1;
		cart_loading    = 1'b0;
		cart_id         = CART_NONE;
		cart_exrom      = 8'h01;
		cart_game       = 8'h01;
		cart_boot       = 1'b0;
		cart_bank_wr    = 1'b0;
		cart_bank_num   = '0;
		cart_bank_laddr = '0;
		cart_bank_size  = '0;
		cart_bank_raddr = '0;
		romL            = 1'b0;
		romH            = 1'b0;
		IOE             = 1'b0;
		mem_write       = 1'b0;
		addr_in         = '0;
		data_in         = '0;
		n_cmds          = 0;
		n_checks        = 0;
		done            = 1'b0;
		fd = $fopen("cart_input.txt", "r");
		if (fd == 0) fail_run("Cannot open cart_input.txt");
		repeat (10) @(posedge clk32);
		@(negedge clk32);
		reset_n = 1'b0;
		wait_lines_off(SETTLE_MAX);
		while (!done) begin
			if (n_cmds == MAX_CMDS) fail_run("Timeout: too many commands in cart_input.txt");
			r = $fscanf(fd, "%s", cmd);
			if (r != 1) begin
				done = 1'b1; // End of file
			end else begin
				n_cmds++;
				run_command(cmd);
			end
		end
		$fclose(fd);
		if (n_checks == 0) begin
			$display("*** FAILED ***");
			$fatal(1, "No expected values found in cart_input.txt");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

//--- cart_input.txt
# I id exrom game boot | L num laddr size raddr | W addr data | R addr
# A roml romh write addr | E exrom game mem_addr mem_write_out data_floating (all hex)
A 0 0 0 00800
E 1 1 0040800 0 0
A 1 0 0 08123
E 1 1 0200123 0 1
I 0000 00 00 0
L 0000 8000 4000 0206000
A 1 0 0 08010
E 0 0 0206010 0 0
A 0 1 0 0a020
E 0 0 0208020 0 0
I 0005 00 00 0
W 0de00 05
A 1 0 0 08100
E 0 0 020a100 0 0
L 0020 8000 2000 0240000
A 0 1 0 0a000
E 0 1 020a000 0 0
I 000f 00 00 0
W 0de07 00
A 1 0 0 08004
E 0 1 020e004 0 0
R 0de00
A 1 0 0 08004
E 0 1 0200004 0 0
I 0013 00 00 0
L 0000 8000 2000 0200000
W 0de00 1b
A 1 0 0 08000
E 0 1 0216000 0 0
W 0de00 85
A 1 0 0 08000
E 1 1 020a000 0 0
I 0020 00 00 1
L 0000 8000 2000 0204000
L 0000 e000 2000 0206000
L 0001 8000 2000 020a000
L 0001 e000 2000 020c000
A 1 0 0 08010
E 1 0 0204010 0 0
A 1 0 1 08010
E 1 0 0048010 0 0
W 0de00 01
W 0de02 07
A 1 0 0 08010
E 0 0 020a010 0 0
A 0 1 0 0e010
E 0 0 020c010 0 0
A 1 0 1 08010
E 0 0 0048010 1 0
I 0005 00 00 0
E 1 1 0048010 1 0
E 0 0 0048010 1 0

//--- filelist.f
cart_pkg.sv
bank_state_if.sv
bank_table.sv
cart_mapper.sv
addr_translate.sv
cartridge.sv
tb_cartridge.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --timing -Wno-fatal
TOP      = tb_cartridge
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only -Wall $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
